//--- dpath_pkg.sv
// Dual-issue datapath package
// Widths, reset vector, mux select encodings and the per-lane control word
package dpath_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  localparam word_t RESET_VECTOR = 32'h00080000;
  localparam word_t INST_BYTES   = 32'd4;

  // ALU functions, CP1 passes operand 1 through
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
    ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_CP1
  } alu_fn_t;

  typedef enum logic [1:0] {
    PC_PLUS8, PC_BRANCH, PC_JUMP, PC_JUMPREG
  } pc_sel_t;

  typedef enum logic [2:0] {
    BYP_RF, BYP_X_A, BYP_X_B, BYP_W_A, BYP_W_B
  } byp_sel_t;

  typedef enum logic [1:0] {
    OP0_BYP, OP0_PC, OP0_PC4, OP0_ZERO
  } op0_sel_t;

  typedef enum logic [2:0] {
    OP1_BYP, OP1_SHAMT, OP1_IMM_U, OP1_IMM_SB, OP1_IMM_I, OP1_IMM_S, OP1_ZERO
  } op1_sel_t;

  // Controls for one lane, applied in D and carried down the pipe
  typedef struct packed {
    byp_sel_t byp0;
    byp_sel_t byp1;
    op0_sel_t op0;
    op1_sel_t op1;
    alu_fn_t  alu_fn;
    logic     wen;
  } lane_ctl_t;

endpackage

//--- dpath_ifs.sv
// Datapath interfaces
// Bypass results from X and W, and the two register file write ports
`timescale 1ns/1ps

interface bypass_if;
  dpath_pkg::word_t x_a;
  dpath_pkg::word_t x_b;
  dpath_pkg::word_t w_a;
  dpath_pkg::word_t w_b;

  modport src_x (output x_a, x_b);
  modport src_w (output w_a, w_b);
  modport sink  (input x_a, x_b, w_a, w_b);
endinterface

interface rf_write_if;
  logic                 wen_a;
  dpath_pkg::reg_idx_t  waddr_a;
  dpath_pkg::word_t     wdata_a;
  logic                 wen_b;
  dpath_pkg::reg_idx_t  waddr_b;
  dpath_pkg::word_t     wdata_b;

  modport wr (output wen_a, waddr_a, wdata_a, wen_b, waddr_b, wdata_b);
  modport rf (input wen_a, waddr_a, wdata_a, wen_b, waddr_b, wdata_b);
endinterface

//--- alu.sv
// Integer ALU
// Add, subtract, logic, compares and shifts on two 32-bit operands
`timescale 1ns/1ps

module alu (
  input  dpath_pkg::word_t   in0,
  input  dpath_pkg::word_t   in1,
  input  dpath_pkg::alu_fn_t fn,
  output dpath_pkg::word_t   out
);

  logic [4:0] shamt;

  assign shamt = in1[4:0];

  always_comb begin
    case (fn)
      dpath_pkg::ALU_ADD:  out = in0 + in1;
      dpath_pkg::ALU_SUB:  out = in0 - in1;
      dpath_pkg::ALU_AND:  out = in0 & in1;
      dpath_pkg::ALU_OR:   out = in0 | in1;
      dpath_pkg::ALU_XOR:  out = in0 ^ in1;
      dpath_pkg::ALU_SLT:  out = {31'b0, $signed(in0) < $signed(in1)};
      dpath_pkg::ALU_SLTU: out = {31'b0, in0 < in1};
      dpath_pkg::ALU_SLL:  out = in0 << shamt;
      dpath_pkg::ALU_SRL:  out = in0 >> shamt;
      // Arithmetic shift keeps the sign
      dpath_pkg::ALU_SRA:  out = $signed(in0) >>> shamt;
      dpath_pkg::ALU_CP1:  out = in1;
      default:             out = '0;
    endcase
  end

endmodule

//--- inst_fields.sv
// Instruction field decode
// Register indices and the five sign-extended immediate formats
`timescale 1ns/1ps

module inst_fields (
  input  dpath_pkg::word_t    inst,
  output dpath_pkg::reg_idx_t rs1,
  output dpath_pkg::reg_idx_t rs2,
  output dpath_pkg::reg_idx_t rd,
  output logic [4:0]          shamt,
  output dpath_pkg::word_t    imm_i,
  output dpath_pkg::word_t    imm_s,
  output dpath_pkg::word_t    imm_sb,
  output dpath_pkg::word_t    imm_u,
  output dpath_pkg::word_t    imm_uj
);

  assign rs1   = inst[19:15];
  assign rs2   = inst[24:20];
  assign rd    = inst[11:7];
  assign shamt = inst[24:20];

  // Sign always comes from bit 31
  assign imm_i  = {{21{inst[31]}}, inst[30:20]};
  assign imm_s  = {{21{inst[31]}}, inst[30:25], inst[11:7]};
  assign imm_sb = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u  = {inst[31:12], 12'b0};
  assign imm_uj = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

endmodule

//--- lane_operands.sv
// Lane operand select
// Bypass and operand muxes for one lane, plus its branch and jump targets
`timescale 1ns/1ps

module lane_operands (
  input  dpath_pkg::word_t     pc_lane,
  input  dpath_pkg::word_t     pc4_lane,
  input  dpath_pkg::lane_ctl_t ctl,
  input  dpath_pkg::word_t     rdata0,
  input  dpath_pkg::word_t     rdata1,
  input  logic [4:0]           shamt,
  input  dpath_pkg::word_t     imm_i,
  input  dpath_pkg::word_t     imm_s,
  input  dpath_pkg::word_t     imm_sb,
  input  dpath_pkg::word_t     imm_u,
  input  dpath_pkg::word_t     imm_uj,
  bypass_if.sink               byp,
  output dpath_pkg::word_t     op0,
  output dpath_pkg::word_t     op1,
  output dpath_pkg::word_t     store_data,
  output dpath_pkg::word_t     branch_targ,
  output dpath_pkg::word_t     jump_targ,
  output dpath_pkg::word_t     jumpreg_targ
);

  dpath_pkg::word_t byp0_out;
  dpath_pkg::word_t byp1_out;
  dpath_pkg::word_t jr_sum;

  function automatic dpath_pkg::word_t byp_pick(input dpath_pkg::byp_sel_t sel,
                                                input dpath_pkg::word_t   rf_val);
    case (sel)
      dpath_pkg::BYP_RF:  return rf_val;
      dpath_pkg::BYP_X_A: return byp.x_a;
      dpath_pkg::BYP_X_B: return byp.x_b;
      dpath_pkg::BYP_W_A: return byp.w_a;
      dpath_pkg::BYP_W_B: return byp.w_b;
      default:            return '0;
    endcase
  endfunction

  assign byp0_out = byp_pick(ctl.byp0, rdata0);
  assign byp1_out = byp_pick(ctl.byp1, rdata1);

  always_comb begin
    case (ctl.op0)
      dpath_pkg::OP0_BYP: op0 = byp0_out;
      dpath_pkg::OP0_PC:  op0 = pc_lane;
      dpath_pkg::OP0_PC4: op0 = pc4_lane;
      default:            op0 = '0;
    endcase
  end

  always_comb begin
    case (ctl.op1)
      dpath_pkg::OP1_BYP:    op1 = byp1_out;
      dpath_pkg::OP1_SHAMT:  op1 = {27'b0, shamt};
      dpath_pkg::OP1_IMM_U:  op1 = imm_u;
      dpath_pkg::OP1_IMM_SB: op1 = imm_sb;
      dpath_pkg::OP1_IMM_I:  op1 = imm_i;
      dpath_pkg::OP1_IMM_S:  op1 = imm_s;
      default:               op1 = '0;
    endcase
  end

  // Store data is rs2 after bypassing
  assign store_data = byp1_out;

  // --------------------------------------------------
  // Control-flow targets
  // --------------------------------------------------
  assign branch_targ  = pc_lane + imm_sb;
  assign jump_targ    = pc_lane + imm_uj;
  assign jr_sum       = byp0_out + imm_i;
  assign jumpreg_targ = {jr_sum[31:1], 1'b0};

endmodule

//--- regfile.sv
// Register file
// 32 x 32 bits, four combinational reads, two writes, x0 fixed at zero
`timescale 1ns/1ps

module regfile (
  input  logic                clk,
  input  dpath_pkg::reg_idx_t raddr0,
  input  dpath_pkg::reg_idx_t raddr1,
  input  dpath_pkg::reg_idx_t raddr2,
  input  dpath_pkg::reg_idx_t raddr3,
  rf_write_if.rf              wr,
  output dpath_pkg::word_t    rdata0,
  output dpath_pkg::word_t    rdata1,
  output dpath_pkg::word_t    rdata2,
  output dpath_pkg::word_t    rdata3
);

  dpath_pkg::word_t regs [1:31];

  function automatic dpath_pkg::word_t rd_reg(input dpath_pkg::reg_idx_t addr);
    return (addr == '0) ? '0 : regs[addr];
  endfunction

  assign rdata0 = rd_reg(raddr0);
  assign rdata1 = rd_reg(raddr1);
  assign rdata2 = rd_reg(raddr2);
  assign rdata3 = rd_reg(raddr3);

  // Lane B is the younger instruction, its write comes last and wins
  always_ff @(posedge clk) begin
    if (wr.wen_a && wr.waddr_a != '0) begin
      regs[wr.waddr_a] <= wr.wdata_a;
    end
    if (wr.wen_b && wr.waddr_b != '0) begin
      regs[wr.waddr_b] <= wr.wdata_b;
    end
  end

endmodule

//--- fetch_pc.sv
// Fetch PC unit
// Next-PC select, fetch PC register and the PC copies held for decode
`timescale 1ns/1ps

module fetch_pc (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall_f,
  input  logic               stall_d,
  input  dpath_pkg::pc_sel_t pc_sel,
  input  dpath_pkg::word_t   branch_targ,
  input  dpath_pkg::word_t   jump_targ,
  input  dpath_pkg::word_t   jumpreg_targ,
  output dpath_pkg::word_t   imem_addr0,
  output dpath_pkg::word_t   imem_addr1,
  output dpath_pkg::word_t   pc_d,
  output dpath_pkg::word_t   pc4_d,
  output dpath_pkg::word_t   pc8_d
);

  dpath_pkg::word_t pc_f;
  dpath_pkg::word_t pc4_f;
  dpath_pkg::word_t pc8_f;
  dpath_pkg::word_t pc_next;

  assign pc4_f = pc_f + dpath_pkg::INST_BYTES;
  assign pc8_f = pc4_f + dpath_pkg::INST_BYTES;

  always_comb begin
    case (pc_sel)
      dpath_pkg::PC_BRANCH:  pc_next = branch_targ;
      dpath_pkg::PC_JUMP:    pc_next = jump_targ;
      dpath_pkg::PC_JUMPREG: pc_next = jumpreg_targ;
      default:               pc_next = pc8_f;
    endcase
  end

  // Fetch request goes out in the same cycle as the select
  assign imem_addr0 = reset ? dpath_pkg::RESET_VECTOR : pc_next;
  assign imem_addr1 = imem_addr0 + dpath_pkg::INST_BYTES;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= dpath_pkg::RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f <= pc_next;
    end
  end

  // Decode-stage copies
  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_d  <= pc_f;
      pc4_d <= pc4_f;
      pc8_d <= pc8_f;
    end
  end

  // Targets come from decode, so a bad immediate shows up here
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    !stall_f |=> pc_f[1:0] == 2'b00);

endmodule

//--- execute_stage.sv
// Execute stage
// X registers for both lanes, two ALUs, branch flags and the data memory request
`timescale 1ns/1ps

module execute_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall_x,
  input  dpath_pkg::word_t     op0_a,
  input  dpath_pkg::word_t     op1_a,
  input  dpath_pkg::word_t     op0_b,
  input  dpath_pkg::word_t     op1_b,
  input  dpath_pkg::word_t     store_data,
  input  dpath_pkg::lane_ctl_t ctl_a,
  input  dpath_pkg::lane_ctl_t ctl_b,
  input  dpath_pkg::reg_idx_t  rd_a,
  input  dpath_pkg::reg_idx_t  rd_b,
  output dpath_pkg::word_t     dmem_addr,
  output dpath_pkg::word_t     dmem_wdata,
  output logic                 br_eq,
  output logic                 br_ne,
  output logic                 br_lt,
  output logic                 br_ltu,
  output logic                 br_ge,
  output logic                 br_geu,
  output dpath_pkg::word_t     res_a,
  output dpath_pkg::word_t     res_b,
  output logic                 wen_a,
  output logic                 wen_b,
  output dpath_pkg::reg_idx_t  rd_x_a,
  output dpath_pkg::reg_idx_t  rd_x_b,
  bypass_if.src_x              byp
);

  dpath_pkg::word_t   op0_x_a;
  dpath_pkg::word_t   op1_x_a;
  dpath_pkg::word_t   op0_x_b;
  dpath_pkg::word_t   op1_x_b;
  dpath_pkg::word_t   wdata_x;
  dpath_pkg::alu_fn_t fn_x_a;
  dpath_pkg::alu_fn_t fn_x_b;
  logic               diff_signs;

  // --------------------------------------------------
  // X <- D
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      op0_x_a <= '0;
      op1_x_a <= '0;
      op0_x_b <= '0;
      op1_x_b <= '0;
      wdata_x <= '0;
      fn_x_a  <= dpath_pkg::ALU_ADD;
      fn_x_b  <= dpath_pkg::ALU_ADD;
      wen_a   <= 1'b0;
      wen_b   <= 1'b0;
      rd_x_a  <= '0;
      rd_x_b  <= '0;
    end else if (!stall_x) begin
      op0_x_a <= op0_a;
      op1_x_a <= op1_a;
      op0_x_b <= op0_b;
      op1_x_b <= op1_b;
      wdata_x <= store_data;
      fn_x_a  <= ctl_a.alu_fn;
      fn_x_b  <= ctl_b.alu_fn;
      wen_a   <= ctl_a.wen;
      wen_b   <= ctl_b.wen;
      rd_x_a  <= rd_a;
      rd_x_b  <= rd_b;
    end
  end

  alu alu_a (.in0(op0_x_a), .in1(op1_x_a), .fn(fn_x_a), .out(res_a));
  alu alu_b (.in0(op0_x_b), .in1(op1_x_b), .fn(fn_x_b), .out(res_b));

  assign byp.x_a = res_a;
  assign byp.x_b = res_b;

  // Branch compare uses lane A's subtract, signs settle mixed-sign pairs
  assign diff_signs = op0_x_a[31] ^ op1_x_a[31];
  assign br_eq  = (res_a == '0);
  assign br_ne  = ~br_eq;
  assign br_lt  = diff_signs ? op0_x_a[31] : res_a[31];
  assign br_ltu = diff_signs ? op1_x_a[31] : res_a[31];
  assign br_ge  = diff_signs ? op1_x_a[31] : ~res_a[31];
  assign br_geu = diff_signs ? op0_x_a[31] : ~res_a[31];

  // Memory request leaves during X
  assign dmem_addr  = res_a;
  assign dmem_wdata = wdata_x;

  // Function codes arrive from outside the datapath
  a_fn_defined: assert property (@(posedge clk) disable iff (reset)
    !stall_x |=> fn_x_a inside {[dpath_pkg::ALU_ADD:dpath_pkg::ALU_CP1]}
             && fn_x_b inside {[dpath_pkg::ALU_ADD:dpath_pkg::ALU_CP1]});

endmodule

//--- writeback_stage.sv
// Writeback stage
// W registers, register file writes, W bypass values and CSR write data
`timescale 1ns/1ps

module writeback_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall_w,
  input  dpath_pkg::word_t    res_a,
  input  dpath_pkg::word_t    res_b,
  input  logic                wen_a,
  input  logic                wen_b,
  input  dpath_pkg::reg_idx_t rd_x_a,
  input  dpath_pkg::reg_idx_t rd_x_b,
  output dpath_pkg::word_t    csr_wdata,
  rf_write_if.wr              wr,
  bypass_if.src_w             byp
);

  dpath_pkg::word_t    res_w_a;
  dpath_pkg::word_t    res_w_b;
  logic                wen_w_a;
  logic                wen_w_b;
  dpath_pkg::reg_idx_t rd_w_a;
  dpath_pkg::reg_idx_t rd_w_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      res_w_a <= '0;
      res_w_b <= '0;
      wen_w_a <= 1'b0;
      wen_w_b <= 1'b0;
      rd_w_a  <= '0;
      rd_w_b  <= '0;
    end else if (!stall_w) begin
      res_w_a <= res_a;
      res_w_b <= res_b;
      wen_w_a <= wen_a;
      wen_w_b <= wen_b;
      rd_w_a  <= rd_x_a;
      rd_w_b  <= rd_x_b;
    end
  end

  assign wr.wen_a   = wen_w_a;
  assign wr.waddr_a = rd_w_a;
  assign wr.wdata_a = res_w_a;
  assign wr.wen_b   = wen_w_b;
  assign wr.waddr_b = rd_w_b;
  assign wr.wdata_b = res_w_b;

  assign byp.w_a  = res_w_a;
  assign byp.w_b  = res_w_b;
  assign csr_wdata = res_w_a;

  // Execute stage hands over no write in the cycle after a reset edge
  a_no_wen_in_reset: assert property (@(posedge clk)
    reset |=> !wen_a && !wen_b);

endmodule

//--- dual_dpath_top.sv
// Dual-issue RISC-V datapath, top level
// Fetch PC, two decode lanes, register file, execute and writeback stages
`timescale 1ns/1ps

module dual_dpath_top (
  input  logic                 clk,
  input  logic                 reset,
  input  dpath_pkg::pc_sel_t   pc_sel,
  input  logic                 steer,
  input  dpath_pkg::word_t     inst_a,
  input  dpath_pkg::word_t     inst_b,
  input  dpath_pkg::lane_ctl_t ctl_a,
  input  dpath_pkg::lane_ctl_t ctl_b,
  input  logic                 stall_f,
  input  logic                 stall_d,
  input  logic                 stall_x,
  input  logic                 stall_w,
  output dpath_pkg::word_t     imem_addr0,
  output dpath_pkg::word_t     imem_addr1,
  output dpath_pkg::word_t     dmem_addr,
  output dpath_pkg::word_t     dmem_wdata,
  output dpath_pkg::word_t     csr_wdata,
  output logic                 br_eq,
  output logic                 br_ne,
  output logic                 br_lt,
  output logic                 br_ltu,
  output logic                 br_ge,
  output logic                 br_geu
);

  dpath_pkg::word_t    pc_d, pc4_d, pc8_d;
  dpath_pkg::word_t    pc_a, pc4_a, pc_b, pc4_b;
  dpath_pkg::reg_idx_t rs1_a, rs2_a, rd_a, rs1_b, rs2_b, rd_b;
  logic [4:0]          shamt_a, shamt_b;
  dpath_pkg::word_t    imm_i_a, imm_s_a, imm_sb_a, imm_u_a, imm_uj_a;
  dpath_pkg::word_t    imm_i_b, imm_s_b, imm_sb_b, imm_u_b, imm_uj_b;
  dpath_pkg::word_t    rdata0, rdata1, rdata2, rdata3;
  dpath_pkg::word_t    op0_a, op1_a, op0_b, op1_b, store_data_a;
  dpath_pkg::word_t    branch_targ_a, jump_targ_a, jumpreg_targ_a;
  dpath_pkg::word_t    res_a, res_b;
  logic                wen_x_a, wen_x_b;
  dpath_pkg::reg_idx_t rd_x_a, rd_x_b;

  bypass_if   byp_bus ();
  rf_write_if rf_wr ();

  // --------------------------------------------------
  // Fetch and lane steering
  // --------------------------------------------------
  fetch_pc u_fetch (
    .clk(clk), .reset(reset), .stall_f(stall_f), .stall_d(stall_d),
    .pc_sel(pc_sel), .branch_targ(branch_targ_a), .jump_targ(jump_targ_a),
    .jumpreg_targ(jumpreg_targ_a), .imem_addr0(imem_addr0),
    .imem_addr1(imem_addr1), .pc_d(pc_d), .pc4_d(pc4_d), .pc8_d(pc8_d)
  );

  // Steer swaps which slot of the fetch pair each lane holds
  assign pc_a  = steer ? pc4_d : pc_d;
  assign pc4_a = steer ? pc8_d : pc4_d;
  assign pc_b  = steer ? pc_d  : pc4_d;
  assign pc4_b = steer ? pc4_d : pc8_d;

  // --------------------------------------------------
  // Decode and register read
  // --------------------------------------------------
  inst_fields u_fields_a (
    .inst(inst_a), .rs1(rs1_a), .rs2(rs2_a), .rd(rd_a), .shamt(shamt_a),
    .imm_i(imm_i_a), .imm_s(imm_s_a), .imm_sb(imm_sb_a), .imm_u(imm_u_a),
    .imm_uj(imm_uj_a)
  );

  inst_fields u_fields_b (
    .inst(inst_b), .rs1(rs1_b), .rs2(rs2_b), .rd(rd_b), .shamt(shamt_b),
    .imm_i(imm_i_b), .imm_s(imm_s_b), .imm_sb(imm_sb_b), .imm_u(imm_u_b),
    .imm_uj(imm_uj_b)
  );

  regfile u_rf (
    .clk(clk), .raddr0(rs1_a), .raddr1(rs2_a), .raddr2(rs1_b), .raddr3(rs2_b),
    .wr(rf_wr.rf), .rdata0(rdata0), .rdata1(rdata1), .rdata2(rdata2),
    .rdata3(rdata3)
  );

  lane_operands u_ops_a (
    .pc_lane(pc_a), .pc4_lane(pc4_a), .ctl(ctl_a), .rdata0(rdata0),
    .rdata1(rdata1), .shamt(shamt_a), .imm_i(imm_i_a), .imm_s(imm_s_a),
    .imm_sb(imm_sb_a), .imm_u(imm_u_a), .imm_uj(imm_uj_a), .byp(byp_bus.sink),
    .op0(op0_a), .op1(op1_a), .store_data(store_data_a),
    .branch_targ(branch_targ_a), .jump_targ(jump_targ_a),
    .jumpreg_targ(jumpreg_targ_a)
  );

  // Lane B has no control-flow or store path
  lane_operands u_ops_b (
    .pc_lane(pc_b), .pc4_lane(pc4_b), .ctl(ctl_b), .rdata0(rdata2),
    .rdata1(rdata3), .shamt(shamt_b), .imm_i(imm_i_b), .imm_s(imm_s_b),
    .imm_sb(imm_sb_b), .imm_u(imm_u_b), .imm_uj(imm_uj_b), .byp(byp_bus.sink),
    .op0(op0_b), .op1(op1_b), .store_data(), .branch_targ(), .jump_targ(),
    .jumpreg_targ()
  );

  // --------------------------------------------------
  // Execute and writeback
  // --------------------------------------------------
  execute_stage u_exec (
    .clk(clk), .reset(reset), .stall_x(stall_x), .op0_a(op0_a), .op1_a(op1_a),
    .op0_b(op0_b), .op1_b(op1_b), .store_data(store_data_a), .ctl_a(ctl_a),
    .ctl_b(ctl_b), .rd_a(rd_a), .rd_b(rd_b), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .br_eq(br_eq), .br_ne(br_ne), .br_lt(br_lt),
    .br_ltu(br_ltu), .br_ge(br_ge), .br_geu(br_geu), .res_a(res_a),
    .res_b(res_b), .wen_a(wen_x_a), .wen_b(wen_x_b), .rd_x_a(rd_x_a),
    .rd_x_b(rd_x_b), .byp(byp_bus.src_x)
  );

  writeback_stage u_wb (
    .clk(clk), .reset(reset), .stall_w(stall_w), .res_a(res_a), .res_b(res_b),
    .wen_a(wen_x_a), .wen_b(wen_x_b), .rd_x_a(rd_x_a), .rd_x_b(rd_x_b),
    .csr_wdata(csr_wdata), .wr(rf_wr.wr), .byp(byp_bus.src_w)
  );

endmodule

//--- tb_dual_dpath.sv
// Testbench for the dual-issue datapath
// Table of instruction pairs applied one per cycle, checked against a reference model
`timescale 1ns/1ps

module tb_dual_dpath;

  localparam int MAX_ROWS = 64;
  localparam int WATCHDOG = 400;

  logic clk, reset, steer, stall_f, stall_d, stall_x, stall_w;
  dpath_pkg::pc_sel_t   pc_sel;
  dpath_pkg::word_t     inst_a, inst_b;
  dpath_pkg::lane_ctl_t ctl_a, ctl_b;
  dpath_pkg::word_t     imem_addr0, imem_addr1, dmem_addr, dmem_wdata, csr_wdata;
  logic br_eq, br_ne, br_lt, br_ltu, br_ge, br_geu;

  // Stimulus table
  dpath_pkg::word_t     t_inst_a [MAX_ROWS];
  dpath_pkg::word_t     t_inst_b [MAX_ROWS];
  dpath_pkg::lane_ctl_t t_ctl_a [MAX_ROWS];
  dpath_pkg::lane_ctl_t t_ctl_b [MAX_ROWS];
  dpath_pkg::pc_sel_t   t_pc_sel [MAX_ROWS];
  logic                 t_steer [MAX_ROWS];
  logic                 t_stall_f [MAX_ROWS];
  int n_rows;

  // Reference model state
  dpath_pkg::word_t mregs [32];
  dpath_pkg::word_t ra [MAX_ROWS];
  dpath_pkg::word_t rb [MAX_ROWS];
  dpath_pkg::word_t sd [MAX_ROWS];
  dpath_pkg::word_t m_op0 [MAX_ROWS];
  dpath_pkg::word_t m_op1 [MAX_ROWS];
  dpath_pkg::word_t mpc_f, mpc_d, next_pc;
  logic [31:0] seed;
  int errors;

  dual_dpath_top dut (
    .clk(clk), .reset(reset), .pc_sel(pc_sel), .steer(steer), .inst_a(inst_a),
    .inst_b(inst_b), .ctl_a(ctl_a), .ctl_b(ctl_b), .stall_f(stall_f),
    .stall_d(stall_d), .stall_x(stall_x), .stall_w(stall_w),
    .imem_addr0(imem_addr0), .imem_addr1(imem_addr1), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .csr_wdata(csr_wdata), .br_eq(br_eq), .br_ne(br_ne),
    .br_lt(br_lt), .br_ltu(br_ltu), .br_ge(br_ge), .br_geu(br_geu)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic dpath_pkg::lane_ctl_t make_ctl(
      input dpath_pkg::byp_sel_t b0, b1, input dpath_pkg::op0_sel_t o0,
      input dpath_pkg::op1_sel_t o1, input dpath_pkg::alu_fn_t fn, input logic wen);
    dpath_pkg::lane_ctl_t c;
    c.byp0   = b0;
    c.byp1   = b1;
    c.op0    = o0;
    c.op1    = o1;
    c.alu_fn = fn;
    c.wen    = wen;
    return c;
  endfunction

  // I-type layout, imm12 = {hi7, rs2 field}
  function automatic dpath_pkg::word_t make_inst(input logic [6:0] hi7, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [4:0] rd);
    return {hi7, rs2, rs1, 3'b000, rd, 7'h13};
  endfunction

  function automatic dpath_pkg::word_t ref_imm(input dpath_pkg::word_t inst,
                                               input dpath_pkg::op1_sel_t sel);
    case (sel)
      dpath_pkg::OP1_SHAMT:  return {27'b0, inst[24:20]};
      dpath_pkg::OP1_IMM_U:  return {inst[31:12], 12'h000};
      dpath_pkg::OP1_IMM_SB: return {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                     inst[11:8], 1'b0};
      dpath_pkg::OP1_IMM_I:  return {{20{inst[31]}}, inst[31:20]};
      dpath_pkg::OP1_IMM_S:  return {{20{inst[31]}}, inst[31:25], inst[11:7]};
      default:               return '0;
    endcase
  endfunction

  function automatic dpath_pkg::word_t ref_imm_uj(input dpath_pkg::word_t inst);
    return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  function automatic dpath_pkg::word_t ref_alu(input dpath_pkg::alu_fn_t fn,
                                               input dpath_pkg::word_t a, b);
    case (fn)
      dpath_pkg::ALU_ADD:  return a + b;
      dpath_pkg::ALU_SUB:  return a - b;
      dpath_pkg::ALU_AND:  return a & b;
      dpath_pkg::ALU_OR:   return a | b;
      dpath_pkg::ALU_XOR:  return a ^ b;
      dpath_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      dpath_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      dpath_pkg::ALU_SLL:  return a << b[4:0];
      dpath_pkg::ALU_SRL:  return a >> b[4:0];
      dpath_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
      default:             return b;
    endcase
  endfunction

  // Bypass sources are the results one (X) or two (W) rows back
  function automatic dpath_pkg::word_t ref_byp(input dpath_pkg::byp_sel_t sel,
                                               input dpath_pkg::word_t rf_val, input int row);
    case (sel)
      dpath_pkg::BYP_X_A: return (row >= 1) ? ra[row-1] : '0;
      dpath_pkg::BYP_X_B: return (row >= 1) ? rb[row-1] : '0;
      dpath_pkg::BYP_W_A: return (row >= 2) ? ra[row-2] : '0;
      dpath_pkg::BYP_W_B: return (row >= 2) ? rb[row-2] : '0;
      default:            return rf_val;
    endcase
  endfunction

  task automatic lane_eval(input int row, input dpath_pkg::word_t inst,
                           input dpath_pkg::lane_ctl_t c, input dpath_pkg::word_t pcl,
                           output dpath_pkg::word_t o0, o1, b1);
    dpath_pkg::word_t b0;
    b0 = ref_byp(c.byp0, mregs[inst[19:15]], row);
    b1 = ref_byp(c.byp1, mregs[inst[24:20]], row);
    case (c.op0)
      dpath_pkg::OP0_PC:   o0 = pcl;
      dpath_pkg::OP0_PC4:  o0 = pcl + 32'd4;
      dpath_pkg::OP0_ZERO: o0 = '0;
      default:             o0 = b0;
    endcase
    o1 = (c.op1 == dpath_pkg::OP1_BYP) ? b1 : ref_imm(inst, c.op1);
  endtask

  // Row's writes land in the model three rows later, lane B last
  task automatic commit_row(input int row);
    if (row >= 0) begin
      if (t_ctl_a[row].wen && t_inst_a[row][11:7] != 5'd0)
        mregs[t_inst_a[row][11:7]] = ra[row];
      if (t_ctl_b[row].wen && t_inst_b[row][11:7] != 5'd0)
        mregs[t_inst_b[row][11:7]] = rb[row];
    end
  endtask

  task automatic model_row(input int i);
    dpath_pkg::word_t pa, pb, o0a, o1a, b1a, o0b, o1b, b1b;
    commit_row(i - 3);
    pa = t_steer[i] ? mpc_d + 32'd4 : mpc_d;
    pb = t_steer[i] ? mpc_d : mpc_d + 32'd4;
    lane_eval(i, t_inst_a[i], t_ctl_a[i], pa, o0a, o1a, b1a);
    lane_eval(i, t_inst_b[i], t_ctl_b[i], pb, o0b, o1b, b1b);
    ra[i]    = ref_alu(t_ctl_a[i].alu_fn, o0a, o1a);
    rb[i]    = ref_alu(t_ctl_b[i].alu_fn, o0b, o1b);
    sd[i]    = b1a;
    m_op0[i] = o0a;
    m_op1[i] = o1a;
    case (t_pc_sel[i])
      dpath_pkg::PC_JUMP:   next_pc = pa + ref_imm_uj(t_inst_a[i]);
      dpath_pkg::PC_BRANCH: next_pc = pa + ref_imm(t_inst_a[i], dpath_pkg::OP1_IMM_SB);
      default:              next_pc = mpc_f + 32'd8;
    endcase
  endtask

  task automatic check_word(input string name, input dpath_pkg::word_t got, exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s exp %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_outputs(input int i);
    dpath_pkg::word_t a, b;
    check_word("dmem_addr", dmem_addr, (i >= 1) ? ra[i-1] : '0);
    check_word("dmem_wdata", dmem_wdata, (i >= 1) ? sd[i-1] : '0);
    check_word("csr_wdata", csr_wdata, (i >= 2) ? ra[i-2] : '0);
    if (i >= 1 && t_ctl_a[i-1].alu_fn == dpath_pkg::ALU_SUB) begin
      a = m_op0[i-1];
      b = m_op1[i-1];
      check_bit("br_eq", br_eq, a == b);
      check_bit("br_ne", br_ne, a != b);
      check_bit("br_lt", br_lt, $signed(a) < $signed(b));
      check_bit("br_ltu", br_ltu, a < b);
      check_bit("br_ge", br_ge, $signed(a) >= $signed(b));
      check_bit("br_geu", br_geu, a >= b);
    end
  endtask

  task automatic add_row(input dpath_pkg::word_t ia, ib, input dpath_pkg::lane_ctl_t ca, cb,
                         input dpath_pkg::pc_sel_t ps, input logic st, sf);
    t_inst_a[n_rows]  = ia;
    t_inst_b[n_rows]  = ib;
    t_ctl_a[n_rows]   = ca;
    t_ctl_b[n_rows]   = cb;
    t_pc_sel[n_rows]  = ps;
    t_steer[n_rows]   = st;
    t_stall_f[n_rows] = sf;
    n_rows++;
  endtask

  task automatic build_table();
    dpath_pkg::lane_ctl_t nop, li, ca, cb;
    dpath_pkg::op1_sel_t  o1;
    logic [11:0] pairs [12];
    logic [31:0] r;
    nop = make_ctl(dpath_pkg::BYP_RF, dpath_pkg::BYP_RF, dpath_pkg::OP0_ZERO,
                   dpath_pkg::OP1_ZERO, dpath_pkg::ALU_ADD, 1'b0);
    li  = make_ctl(dpath_pkg::BYP_RF, dpath_pkg::BYP_X_A, dpath_pkg::OP0_ZERO,
                   dpath_pkg::OP1_IMM_I, dpath_pkg::ALU_ADD, 1'b1);
    // --------------------------------------------------
    // Load x1..x31 with random immediates, both lanes
    // --------------------------------------------------
    for (int k = 1; k <= 16; k++) begin
      r = lcg_next();
      add_row(make_inst(r[6:0], r[11:7], 5'd0, 5'(2 * k - 1)),
              make_inst(r[22:16], r[27:23], 5'd0, 5'(2 * k)), li, li,
              dpath_pkg::PC_PLUS8, k[0], 1'b0);
    end
    add_row('0, '0, nop, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    add_row('0, '0, nop, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    // Every ALU function on register, immediate and shift operands
    for (int f = 0; f <= 10; f++) begin
      r  = lcg_next();
      o1 = (f % 3 == 0) ? dpath_pkg::OP1_BYP :
           (f % 3 == 1) ? dpath_pkg::OP1_IMM_I : dpath_pkg::OP1_SHAMT;
      ca = make_ctl(dpath_pkg::BYP_RF, dpath_pkg::BYP_RF, dpath_pkg::OP0_BYP, o1,
                    dpath_pkg::alu_fn_t'(f), 1'b1);
      cb = make_ctl(dpath_pkg::BYP_RF, dpath_pkg::BYP_RF, dpath_pkg::OP0_PC,
                    dpath_pkg::OP1_IMM_U, dpath_pkg::ALU_ADD, 1'b0);
      add_row(make_inst(r[6:0], (o1 == dpath_pkg::OP1_BYP) ? 5'(1 + (f + 3) % 8) : r[11:7],
                        5'(1 + f % 8), 5'(9 + f)),
              lcg_next(), ca, cb, dpath_pkg::PC_PLUS8, r[20], 1'b0);
    end
    ca = make_ctl(dpath_pkg::BYP_RF, dpath_pkg::BYP_RF, dpath_pkg::OP0_PC,
                  dpath_pkg::OP1_IMM_U, dpath_pkg::ALU_ADD, 1'b1);
    add_row({lcg_next() & 32'hffff_f000} | 32'h0000_0b00, '0, ca, nop,
            dpath_pkg::PC_PLUS8, 1'b1, 1'b0);
    // Same-register double write, then an x0 write
    r = lcg_next();
    add_row(make_inst(r[6:0], r[11:7], 5'd0, 5'd3), make_inst(r[18:12], r[23:19], 5'd0, 5'd3),
            li, li, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    add_row(make_inst(7'h2a, 5'h15, 5'd0, 5'd0), '0, li, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    add_row('0, '0, nop, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    ca = make_ctl(dpath_pkg::BYP_RF, dpath_pkg::BYP_RF, dpath_pkg::OP0_BYP,
                  dpath_pkg::OP1_BYP, dpath_pkg::ALU_ADD, 1'b0);
    add_row(make_inst(7'h0, 5'd3, 5'd0, 5'd0), make_inst(7'h0, 5'd5, 5'd1, 5'd23), ca, ca,
            dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    add_row(make_inst(7'h0, 5'd0, 5'd0, 5'd0), '0, ca, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    // --------------------------------------------------
    // Back-to-back bypassing from X and W
    // --------------------------------------------------
    for (int k = 0; k < 6; k++) begin
      ca = make_ctl(dpath_pkg::byp_sel_t'(1 + k % 4), dpath_pkg::byp_sel_t'(1 + (k + 2) % 4),
                    dpath_pkg::OP0_BYP, dpath_pkg::OP1_BYP,
                    k[0] ? dpath_pkg::ALU_SUB : dpath_pkg::ALU_ADD, 1'b1);
      cb = make_ctl(dpath_pkg::byp_sel_t'(1 + (k + 1) % 4), dpath_pkg::BYP_RF,
                    dpath_pkg::OP0_BYP, dpath_pkg::OP1_IMM_I, dpath_pkg::ALU_XOR, 1'b1);
      add_row(lcg_next(), lcg_next(), ca, cb, dpath_pkg::PC_PLUS8, k[1], 1'b0);
    end
    // Compare pairs with mixed signs
    pairs = '{12'hffb, 12'h003, 12'h003, 12'hffb, 12'h007, 12'h007,
              12'hfff, 12'hffe, 12'h7ff, 12'h800, 12'h800, 12'h7ff};
    ca = make_ctl(dpath_pkg::BYP_RF, dpath_pkg::BYP_RF, dpath_pkg::OP0_ZERO,
                  dpath_pkg::OP1_IMM_I, dpath_pkg::ALU_CP1, 1'b0);
    cb = make_ctl(dpath_pkg::BYP_X_A, dpath_pkg::BYP_X_B, dpath_pkg::OP0_BYP,
                  dpath_pkg::OP1_BYP, dpath_pkg::ALU_SUB, 1'b0);
    for (int k = 0; k < 12; k += 2) begin
      add_row({pairs[k], 20'h0}, {pairs[k+1], 20'h0}, ca, ca, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
      add_row('0, '0, cb, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    end
    // Jumps from either steer setting and a fetch stall
    add_row(lcg_next() & 32'hffdf_ffff, '0, nop, nop, dpath_pkg::PC_JUMP, 1'b0, 1'b0);
    add_row('0, '0, nop, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    add_row(lcg_next() & 32'hffdf_ffff, '0, nop, nop, dpath_pkg::PC_JUMP, 1'b1, 1'b0);
    add_row('0, '0, nop, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b1);
    add_row('0, '0, nop, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    add_row('0, '0, nop, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
    add_row('0, '0, nop, nop, dpath_pkg::PC_PLUS8, 1'b0, 1'b0);
  endtask

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Timeout: the table did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    pc_sel = dpath_pkg::PC_PLUS8;
    steer = 1'b0;
    inst_a = '0;
    inst_b = '0;
    ctl_a = '0;
    ctl_b = '0;
    stall_f = 1'b0;
    stall_d = 1'b0;
    stall_x = 1'b0;
    stall_w = 1'b0;
    seed = 32'h45c287de;
    errors = 0;
    n_rows = 0;
    for (int k = 0; k < 32; k++) mregs[k] = '0;
    build_table();
    mpc_f = dpath_pkg::RESET_VECTOR;
    mpc_d = dpath_pkg::RESET_VECTOR;
    for (int c = 0; c < 16; c++) begin
      @(posedge clk);
      @(negedge clk);
      check_word("imem_addr0", imem_addr0, dpath_pkg::RESET_VECTOR);
      check_word("imem_addr1", imem_addr1, dpath_pkg::RESET_VECTOR + 32'd4);
    end
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      reset   <= 1'b0;
      inst_a  <= t_inst_a[i];
      inst_b  <= t_inst_b[i];
      ctl_a   <= t_ctl_a[i];
      ctl_b   <= t_ctl_b[i];
      pc_sel  <= t_pc_sel[i];
      steer   <= t_steer[i];
      stall_f <= t_stall_f[i];
      if (i > 0) begin
        mpc_d = mpc_f;
        if (!t_stall_f[i-1]) mpc_f = next_pc;
      end
      @(negedge clk);
      check_outputs(i);
      model_row(i);
      check_word("imem_addr0", imem_addr0, next_pc);
      check_word("imem_addr1", imem_addr1, next_pc + 32'd4);
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim.f
dpath_pkg.sv
dpath_ifs.sv
alu.sv
inst_fields.sv
lane_operands.sv
regfile.sv
fetch_pc.sv
execute_stage.sv
writeback_stage.sv
dual_dpath_top.sv
tb_dual_dpath.sv
